//--- hdl/csr_pkg.sv
package csr_pkg;

  localparam int unsigned XLEN = 64;

  // A, C, I, M and U with MXL of 2 for RV64
  localparam logic [XLEN-1:0] MISA_VALUE =
      (64'(2) << 62)
    | (64'(1) << 20)
    | (64'(1) << 12)
    | (64'(1) << 8)
    | (64'(1) << 2)
    | (64'(1) << 0);

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_H = 2'd2,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  typedef enum logic [1:0] {
    CSR_OP_READ,
    CSR_OP_WRITE,
    CSR_OP_SET,
    CSR_OP_CLEAR
  } csr_op_e;

  typedef enum logic [11:0] {
    CSR_CYCLE         = 12'hC00,
    CSR_INSTRET       = 12'hC02,
    CSR_MVENDORID     = 12'hF11,
    CSR_MARCHID       = 12'hF12,
    CSR_MIMPID        = 12'hF13,
    CSR_MHARTID       = 12'hF14,
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTEREN    = 12'h306,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02
  } csr_num_e;

  // Bit 4 set means interrupt
  typedef enum logic [4:0] {
    EXC_CAUSE_ILLEGAL_INSN     = 5'h02,
    EXC_CAUSE_BREAKPOINT       = 5'h03,
    EXC_CAUSE_ECALL_UMODE      = 5'h08,
    EXC_CAUSE_ECALL_MMODE      = 5'h0B,
    EXC_CAUSE_IRQ_SOFTWARE_M   = 5'h13,
    EXC_CAUSE_IRQ_TIMER_M      = 5'h17,
    EXC_CAUSE_IRQ_EXTERNAL_M   = 5'h1B
  } exc_cause_e;

  typedef struct packed {
    logic      mie;
    logic      mpie;
    priv_lvl_e mpp;
  } status_t;

  typedef struct packed {
    logic software_m;
    logic timer_m;
    logic external_m;
  } irqs_t;

  typedef struct packed {
    exc_cause_e cause;
  } exception_t;

  typedef struct packed {
    csr_num_e         addr;
    csr_op_e          op;
    logic             en;
    logic [XLEN-1:0]  wdata;
  } csr_req_t;

  //////////////////////////////////////////////////
  // Architectural word layouts
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [63:13] wpri_63_13;
    priv_lvl_e    mpp;
    logic [10:8]  wpri_10_8;
    logic         mpie;
    logic [6:4]   wpri_6_4;
    logic         mie;
    logic [2:0]   wpri_2_0;
  } status_word_t;

  typedef struct packed {
    logic [63:12] zero_63_12;
    logic         mei;
    logic [10:8]  zero_10_8;
    logic         mti;
    logic [6:4]   zero_6_4;
    logic         msi;
    logic [2:0]   zero_2_0;
  } irq_word_t;

  typedef union packed {
    logic [XLEN-1:0] raw;
    status_word_t    status_w;
    irq_word_t       irq_w;
  } csr_word_u;

endpackage

//--- hdl/csr_access_check.sv
`timescale 1ns/1ps

module csr_access_check (
  input  csr_pkg::csr_num_e  check_addr_i,
  input  csr_pkg::csr_op_e   check_op_i,
  input  csr_pkg::priv_lvl_e priv_i,
  input  logic [2:0]         mcounteren_i,
  output logic               check_illegal_o
);

  import csr_pkg::*;

  logic illegal_addr;
  logic illegal_readonly;
  logic illegal_prv;

  always_comb begin
    illegal_addr = 1'b0;
    // Top two address bits both set marks the read-only space
    illegal_readonly = (check_addr_i[11:10] == 2'b11) && (check_op_i != CSR_OP_READ);
    illegal_prv = check_addr_i[9:8] > priv_i;

    unique case (check_addr_i)
      CSR_CYCLE, CSR_INSTRET: begin
        // Low address bits select the mcounteren bit
        if (priv_i == PRIV_LVL_U && !mcounteren_i[check_addr_i[1:0]]) begin
          illegal_addr = 1'b1;
        end
      end
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID:;
      CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MCOUNTEREN:;
      CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MIP:;
      CSR_MCYCLE, CSR_MINSTRET, CSR_MCOUNTINHIBIT:;
      default: illegal_addr = 1'b1;
    endcase

    check_illegal_o = illegal_addr | illegal_readonly | illegal_prv;
  end

endmodule

//--- hdl/csr_irq_ctrl.sv
`timescale 1ns/1ps

module csr_irq_ctrl (
  input  logic                irq_software_m_i,
  input  logic                irq_timer_m_i,
  input  logic                irq_external_m_i,
  input  csr_pkg::irqs_t      mie_i,
  input  csr_pkg::status_t    status_i,
  input  csr_pkg::priv_lvl_e  priv_i,
  output csr_pkg::irqs_t      mip_o,
  output logic                irq_pending_o,
  output logic                irq_valid_o,
  output csr_pkg::exc_cause_e irq_cause_o
);

  import csr_pkg::*;

  irqs_t pending;

  // Machine lines feed mip directly, nothing is software writable
  assign mip_o.software_m = irq_software_m_i;
  assign mip_o.timer_m    = irq_timer_m_i;
  assign mip_o.external_m = irq_external_m_i;

  always_comb begin
    pending = irqs_t'(mip_o & mie_i);
    irq_pending_o = |pending;
    // Below M the global enable is ignored
    irq_valid_o = irq_pending_o && (priv_i != PRIV_LVL_M || status_i.mie);

    // External first, then software, then timer
    if (pending.external_m) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (pending.software_m) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end

    // A valid request must name a line that is both raised and enabled
    if (irq_valid_o) begin
      assert ((irq_cause_o == EXC_CAUSE_IRQ_EXTERNAL_M && irq_external_m_i && mie_i.external_m)
           || (irq_cause_o == EXC_CAUSE_IRQ_SOFTWARE_M && irq_software_m_i && mie_i.software_m)
           || (irq_cause_o == EXC_CAUSE_IRQ_TIMER_M && irq_timer_m_i && mie_i.timer_m))
        else $error("irq valid without an enabled pending source");
    end
  end

endmodule

//--- hdl/csr_trap_regs.sv
`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          wr_en_i,
  input  csr_pkg::csr_num_e             wr_addr_i,
  input  csr_pkg::csr_word_u            wr_data_i,

  input  logic                          ex_valid_i,
  input  csr_pkg::exception_t           ex_exception_i,
  input  logic [csr_pkg::XLEN-1:0]      ex_epc_i,
  input  logic                          er_valid_i,

  output csr_pkg::priv_lvl_e            priv_o,
  output csr_pkg::status_t              status_o,
  output csr_pkg::irqs_t                mie_o,
  output logic [csr_pkg::XLEN-1:0]      mtvec_o,
  output logic [csr_pkg::XLEN-1:0]      mepc_o,
  output logic [csr_pkg::XLEN-1:0]      mscratch_o,
  output csr_pkg::exc_cause_e           mcause_o,
  output logic [2:0]                    mcounteren_o,
  output logic [csr_pkg::XLEN-1:0]      ex_tvec_o,
  output logic [csr_pkg::XLEN-1:0]      er_epc_o
);

  import csr_pkg::*;

  priv_lvl_e       priv_q, priv_d;
  status_t         mstatus_q, mstatus_d;
  irqs_t           mie_q, mie_d;
  logic [XLEN-1:0] mtvec_q, mtvec_d;
  logic [XLEN-1:0] mepc_q, mepc_d;
  logic [XLEN-1:0] mscratch_q, mscratch_d;
  exc_cause_e      mcause_q, mcause_d;
  logic [2:0]      mcounteren_q, mcounteren_d;

  assign priv_o       = priv_q;
  assign status_o     = mstatus_q;
  assign mie_o        = mie_q;
  assign mtvec_o      = mtvec_q;
  assign mepc_o       = mepc_q;
  assign mscratch_o   = mscratch_q;
  assign mcause_o     = mcause_q;
  assign mcounteren_o = mcounteren_q;

  // Direct mode only, so the vector is the base itself
  assign ex_tvec_o = mtvec_q;
  assign er_epc_o  = mepc_q;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    priv_d       = priv_q;
    mstatus_d    = mstatus_q;
    mie_d        = mie_q;
    mtvec_d      = mtvec_q;
    mepc_d       = mepc_q;
    mscratch_d   = mscratch_q;
    mcause_d     = mcause_q;
    mcounteren_d = mcounteren_q;

    if (ex_valid_i) begin
      mepc_d         = ex_epc_i;
      mcause_d       = ex_exception_i.cause;
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mstatus_d.mpp  = priv_q;
      priv_d         = PRIV_LVL_M;
    end else if (er_valid_i) begin
      priv_d         = mstatus_q.mpp;
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
      mstatus_d.mpp  = PRIV_LVL_U;
    end else if (wr_en_i) begin
      unique case (wr_addr_i)
        CSR_MSTATUS: begin
          mstatus_d.mie  = wr_data_i.status_w.mie;
          mstatus_d.mpie = wr_data_i.status_w.mpie;
          // Only U and M exist, anything else lands on M
          mstatus_d.mpp  = (wr_data_i.status_w.mpp == PRIV_LVL_U) ? PRIV_LVL_U : PRIV_LVL_M;
        end
        CSR_MIE: begin
          mie_d.software_m = wr_data_i.irq_w.msi;
          mie_d.timer_m    = wr_data_i.irq_w.mti;
          mie_d.external_m = wr_data_i.irq_w.mei;
        end
        CSR_MTVEC:      mtvec_d = {wr_data_i.raw[XLEN-1:2], 2'b00};
        CSR_MEPC:       mepc_d = {wr_data_i.raw[XLEN-1:1], 1'b0};
        CSR_MSCRATCH:   mscratch_d = wr_data_i.raw;
        CSR_MCAUSE:     mcause_d = exc_cause_e'({wr_data_i.raw[XLEN-1], wr_data_i.raw[3:0]});
        CSR_MCOUNTEREN: mcounteren_d = wr_data_i.raw[2:0] & 3'b101;
        default:;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_q       <= PRIV_LVL_M;
      mstatus_q    <= status_t'('0);
      mie_q        <= irqs_t'('0);
      mtvec_q      <= '0;
      mepc_q       <= '0;
      mscratch_q   <= '0;
      mcause_q     <= exc_cause_e'('0);
      mcounteren_q <= '0;
    end else begin
      priv_q       <= priv_d;
      mstatus_q    <= mstatus_d;
      mie_q        <= mie_d;
      mtvec_q      <= mtvec_d;
      mepc_q       <= mepc_d;
      mscratch_q   <= mscratch_d;
      mcause_q     <= mcause_d;
      mcounteren_q <= mcounteren_d;
    end
  end

  // H level is reserved and must never be entered, even via a trap return
  assert property (@(posedge clk_i) disable iff (!rst_ni) priv_q != PRIV_LVL_H);

  // The pipeline retires a trap and a return in different cycles
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(ex_valid_i && er_valid_i));

endmodule

//--- hdl/csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wr_en_i,
  input  csr_pkg::csr_num_e        wr_addr_i,
  input  logic [csr_pkg::XLEN-1:0] wr_data_i,
  input  logic                     instr_ret_i,
  output logic [csr_pkg::XLEN-1:0] mcycle_o,
  output logic [csr_pkg::XLEN-1:0] minstret_o,
  output logic [2:0]               mcountinhibit_o
);

  import csr_pkg::*;

  logic [XLEN-1:0] mcycle_q, mcycle_d;
  logic [XLEN-1:0] minstret_q, minstret_d;
  logic [2:0]      mcountinhibit_q, mcountinhibit_d;

  assign mcycle_o        = mcycle_q;
  assign minstret_o      = minstret_q;
  assign mcountinhibit_o = mcountinhibit_q;

  always_comb begin
    mcycle_d        = mcycle_q;
    minstret_d      = minstret_q;
    mcountinhibit_d = mcountinhibit_q;

    if (!mcountinhibit_q[0]) begin
      mcycle_d = mcycle_q + 1'b1;
    end
    if (!mcountinhibit_q[2] && instr_ret_i) begin
      minstret_d = minstret_q + 1'b1;
    end

    // A CSR write overrides this cycle's increment
    if (wr_en_i) begin
      unique case (wr_addr_i)
        CSR_MCYCLE:        mcycle_d = wr_data_i;
        CSR_MINSTRET:      minstret_d = wr_data_i;
        // No time counter, so bit 1 stays zero
        CSR_MCOUNTINHIBIT: mcountinhibit_d = wr_data_i[2:0] & 3'b101;
        default:;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q        <= '0;
      minstret_q      <= '0;
      mcountinhibit_q <= '0;
    end else begin
      mcycle_q        <= mcycle_d;
      minstret_q      <= minstret_d;
      mcountinhibit_q <= mcountinhibit_d;
    end
  end

  // Held at zero for the whole reset
  assert property (@(posedge clk_i) !rst_ni |-> (mcycle_q == '0 && minstret_q == '0));

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [csr_pkg::XLEN-1:0] hart_id_i,

  // Access check
  input  csr_pkg::csr_num_e        check_addr_i,
  input  csr_pkg::csr_op_e         check_op_i,
  output logic                     check_illegal_o,

  // CSR request
  input  csr_pkg::csr_req_t        req_i,
  output logic [csr_pkg::XLEN-1:0] csr_rdata_o,

  // Interrupts
  input  logic                     irq_software_m_i,
  input  logic                     irq_timer_m_i,
  input  logic                     irq_external_m_i,
  output logic                     irq_pending_o,
  output logic                     irq_valid_o,
  output csr_pkg::exc_cause_e      irq_cause_o,

  // Trap entry and return
  input  logic                     ex_valid_i,
  input  csr_pkg::exception_t      ex_exception_i,
  input  logic [csr_pkg::XLEN-1:0] ex_epc_i,
  output logic [csr_pkg::XLEN-1:0] ex_tvec_o,
  input  logic                     er_valid_i,
  output logic [csr_pkg::XLEN-1:0] er_epc_o,

  input  logic                     instr_ret_i,
  output csr_pkg::priv_lvl_e       priv_mode_o,
  output csr_pkg::status_t         status_o
);

  import csr_pkg::*;

  priv_lvl_e       priv;
  status_t         status;
  irqs_t           mie;
  irqs_t           mip;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mscratch;
  exc_cause_e      mcause;
  logic [2:0]      mcounteren;
  logic [XLEN-1:0] mcycle;
  logic [XLEN-1:0] minstret;
  logic [2:0]      mcountinhibit;
  csr_word_u       rdata;
  csr_word_u       wdata_eff;
  logic            wr_en;

  assign priv_mode_o = priv;
  assign status_o    = status;
  assign csr_rdata_o = rdata.raw;
  assign wr_en       = req_i.en && (req_i.op != CSR_OP_READ);

  function automatic csr_word_u irq_word(irqs_t irqs);
    csr_word_u w;
    w.raw     = '0;
    w.irq_w.msi = irqs.software_m;
    w.irq_w.mti = irqs.timer_m;
    w.irq_w.mei = irqs.external_m;
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    rdata.raw = '0;
    unique case (req_i.addr)
      CSR_MSTATUS: begin
        rdata.status_w.mie  = status.mie;
        rdata.status_w.mpie = status.mpie;
        rdata.status_w.mpp  = status.mpp;
      end
      CSR_MIE:                rdata = irq_word(mie);
      CSR_MIP:                rdata = irq_word(mip);
      CSR_MISA:               rdata.raw = MISA_VALUE;
      CSR_MHARTID:            rdata.raw = hart_id_i;
      CSR_MTVEC:              rdata.raw = mtvec;
      CSR_MEPC:               rdata.raw = mepc;
      CSR_MSCRATCH:           rdata.raw = mscratch;
      // Interrupt flag moves to the top bit
      CSR_MCAUSE:             rdata.raw = {mcause[4], 59'b0, mcause[3:0]};
      CSR_MCOUNTEREN:         rdata.raw = {61'b0, mcounteren};
      CSR_MCOUNTINHIBIT:      rdata.raw = {61'b0, mcountinhibit};
      CSR_CYCLE, CSR_MCYCLE:     rdata.raw = mcycle;
      CSR_INSTRET, CSR_MINSTRET: rdata.raw = minstret;
      default:;
    endcase
  end

  // Set and clear combine with the current value
  always_comb begin
    unique case (req_i.op)
      CSR_OP_WRITE: wdata_eff.raw = req_i.wdata;
      CSR_OP_SET:   wdata_eff.raw = rdata.raw | req_i.wdata;
      CSR_OP_CLEAR: wdata_eff.raw = rdata.raw & ~req_i.wdata;
      default:      wdata_eff.raw = rdata.raw;
    endcase
  end

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  csr_access_check check_i (
    .check_addr_i, .check_op_i, .priv_i(priv), .mcounteren_i(mcounteren), .check_illegal_o
  );

  csr_irq_ctrl irq_ctrl_i (
    .irq_software_m_i, .irq_timer_m_i, .irq_external_m_i,
    .mie_i(mie), .status_i(status), .priv_i(priv),
    .mip_o(mip), .irq_pending_o, .irq_valid_o, .irq_cause_o
  );

  csr_trap_regs trap_regs_i (
    .clk_i, .rst_ni,
    .wr_en_i(wr_en), .wr_addr_i(req_i.addr), .wr_data_i(wdata_eff),
    .ex_valid_i, .ex_exception_i, .ex_epc_i, .er_valid_i,
    .priv_o(priv), .status_o(status), .mie_o(mie),
    .mtvec_o(mtvec), .mepc_o(mepc), .mscratch_o(mscratch),
    .mcause_o(mcause), .mcounteren_o(mcounteren),
    .ex_tvec_o, .er_epc_o
  );

  csr_counters counters_i (
    .clk_i, .rst_ni,
    .wr_en_i(wr_en), .wr_addr_i(req_i.addr), .wr_data_i(wdata_eff.raw),
    .instr_ret_i,
    .mcycle_o(mcycle), .minstret_o(minstret), .mcountinhibit_o(mcountinhibit)
  );

endmodule

//--- bench/csr_file_tb.sv
`timescale 1ns/1ps

module csr_file_tb;

  import csr_pkg::*;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic [XLEN-1:0] hart_id;
  csr_num_e        check_addr;
  csr_op_e         check_op;
  logic            check_illegal;
  csr_req_t        req;
  logic [XLEN-1:0] rdata;
  logic            irq_sw, irq_tmr, irq_ext;
  logic            irq_pending, irq_valid;
  exc_cause_e      irq_cause;
  logic            ex_valid, er_valid, instr_ret;
  exception_t      ex_exc;
  logic [XLEN-1:0] ex_epc, ex_tvec, er_epc;
  priv_lvl_e       priv_mode;
  status_t         status;

  // Steps loaded from the input file
  logic [7:0]      kinds[$];
  logic [XLEN-1:0] addrs[$];
  logic [XLEN-1:0] datas[$];
  logic [XLEN-1:0] exps[$];

  int pass_count = 0;
  int fail_count = 0;
  int test_checks = 0;
  int test_fails = 0;
  int cycle_count = 0;
  int cycle_limit = 1000;

  csr_file csr_file_i (
    .clk_i, .rst_ni, .hart_id_i(hart_id),
    .check_addr_i(check_addr), .check_op_i(check_op), .check_illegal_o(check_illegal),
    .req_i(req), .csr_rdata_o(rdata),
    .irq_software_m_i(irq_sw), .irq_timer_m_i(irq_tmr), .irq_external_m_i(irq_ext),
    .irq_pending_o(irq_pending), .irq_valid_o(irq_valid), .irq_cause_o(irq_cause),
    .ex_valid_i(ex_valid), .ex_exception_i(ex_exc), .ex_epc_i(ex_epc), .ex_tvec_o(ex_tvec),
    .er_valid_i(er_valid), .er_epc_o(er_epc),
    .instr_ret_i(instr_ret), .priv_mode_o(priv_mode), .status_o(status)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
    test_checks = test_checks + 1;
    if (got !== exp) begin
      $display("Error at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
      fail_count = fail_count + 1;
      test_fails = test_fails + 1;
    end else begin
      pass_count = pass_count + 1;
    end
  endtask

  task automatic load_steps();
    int              fd;
    int              code;
    logic [7:0]      kind;
    logic [XLEN-1:0] a, d, e;
    logic [8*256-1:0] rest;
    fd = $fopen("bench/csr_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/csr_input.txt for reading");
      fail_count = fail_count + 1;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", kind);
        if (code == 1) begin
          // Comment lines are skipped whole
          if (kind == "#") begin
            code = $fgets(rest, fd);
          end else begin
            code = $fscanf(fd, "%h %h %h", a, d, e);
            if (code == 3) begin
              kinds.push_back(kind);
              addrs.push_back(a);
              datas.push_back(d);
              exps.push_back(e);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_step(input int idx);
    logic [7:0]      kind;
    logic [XLEN-1:0] a, d, e;
    logic [XLEN-1:0] irq_word;
    int              count;
    kind = kinds[idx];
    a = addrs[idx];
    d = datas[idx];
    e = exps[idx];
    count = int'(d);
    @(posedge clk_i);
    // Pulses last one cycle unless the step drives them again
    req.en    <= 1'b0;
    ex_valid  <= 1'b0;
    er_valid  <= 1'b0;
    instr_ret <= 1'b0;
    case (kind)
      "W", "S", "C": begin
        req.addr  <= csr_num_e'(a[11:0]);
        req.op    <= (kind == "W") ? CSR_OP_WRITE : (kind == "S") ? CSR_OP_SET : CSR_OP_CLEAR;
        req.wdata <= d;
        req.en    <= 1'b1;
      end
      "R": begin
        req.addr <= csr_num_e'(a[11:0]);
        req.op   <= CSR_OP_READ;
        @(negedge clk_i);
        check_value(rdata, e, $sformatf("read of CSR %h", a[11:0]));
        // Mstatus reads also check the status output port
        if (a[11:0] == CSR_MSTATUS) begin
          check_value(XLEN'(status), XLEN'({e[3], e[7], e[12:11]}), "status output");
        end
      end
      "K": begin
        check_addr <= csr_num_e'(a[11:0]);
        check_op   <= csr_op_e'(d[1:0]);
        @(negedge clk_i);
        check_value(XLEN'(check_illegal), e, $sformatf("legality of CSR %h", a[11:0]));
      end
      "E": begin
        ex_valid     <= 1'b1;
        ex_exc.cause <= exc_cause_e'(a[4:0]);
        ex_epc       <= d;
        @(negedge clk_i);
        check_value(ex_tvec, e, "trap vector");
      end
      "X": begin
        er_valid <= 1'b1;
        @(negedge clk_i);
        check_value(er_epc, e, "return epc");
      end
      "N": begin
        instr_ret <= (count > 0);
        for (int k = 1; k < count; k++) begin
          @(posedge clk_i);
          instr_ret <= 1'b1;
        end
      end
      "I": begin
        irq_sw  <= d[0];
        irq_tmr <= d[1];
        irq_ext <= d[2];
        @(negedge clk_i);
        // Cause in bits 4:0, pending at 8, valid at 12
        irq_word = '0;
        irq_word[4:0] = irq_cause;
        irq_word[8] = irq_pending;
        irq_word[12] = irq_valid;
        check_value(irq_word, e, "interrupt outputs");
      end
      "P": begin
        @(negedge clk_i);
        check_value(XLEN'(priv_mode), e, "privilege level");
      end
      "T": begin
        $display("Test %0d done: %0d checks, %0d failed", count, test_checks, test_fails);
        test_checks = 0;
        test_fails = 0;
      end
      default: begin
        $display("Unknown step kind %c in the input file", kind);
        fail_count = fail_count + 1;
      end
    endcase
  endtask

  initial begin
    rst_ni     = 1'b0;
    hart_id    = 64'h5;
    check_addr = CSR_MSTATUS;
    check_op   = CSR_OP_READ;
    req        = csr_req_t'('0);
    irq_sw     = 1'b0;
    irq_tmr    = 1'b0;
    irq_ext    = 1'b0;
    ex_valid   = 1'b0;
    ex_exc     = exception_t'('0);
    ex_epc     = '0;
    er_valid   = 1'b0;
    instr_ret  = 1'b0;

    load_steps();
    cycle_limit = 20 * kinds.size() + 100;

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < kinds.size(); i++) begin
      run_step(i);
    end
    @(posedge clk_i);
    req.en <= 1'b0;

    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- bench/csr_input.txt
# kind addr data expected, all hex. W/S/C write ops, R read, K legality (data is op),
# E trap (addr cause, data epc), X return, N instr_ret pulses, I irq lines, P priv, T end
W 340 00000000F0F0F0F0 0
R 340 0 00000000F0F0F0F0
S 340 0000FF000000000F 0
R 340 0 0000FF00F0F0F0FF
C 340 00000000F00000F0 0
R 340 0 0000FF0000F0F00F
W 305 0000000080001003 0
R 305 0 0000000080001000
W 341 0000000000002001 0
R 341 0 0000000000002000
R 301 0 8000000000101105
R F14 0 5
T 0 1 0
W 300 8 0
R 300 0 8
E 0B 4000 80001000
R 341 0 4000
R 342 0 B
R 300 0 1880
P 0 0 3
T 0 2 0
W 300 80 0
X 0 0 4000
P 0 0 0
R 300 0 88
T 0 3 0
K 300 0 1
K 341 1 1
K C00 0 1
W 306 1 0
R 306 0 1
K C00 0 0
K C02 0 1
E 08 100 80001000
P 0 0 3
K F14 1 1
K F14 0 0
K 7C0 0 1
K 300 1 0
T 0 4 0
W 304 880 0
R 304 0 880
I 0 6 11B
W 300 8 0
I 0 6 111B
W 300 0 0
X 0 0 100
P 0 0 0
I 0 6 111B
I 0 1 17
I 0 0 17
T 0 5 0
W 320 5 0
R 320 0 5
W B00 00000000DEADBEEF 0
R B00 0 00000000DEADBEEF
R C00 0 00000000DEADBEEF
C 320 4 0
R 320 0 1
W B02 0 0
N 0 5 0
R B02 0 5
R C02 0 5
T 0 6 0

//--- csr_file.f
hdl/csr_pkg.sv
hdl/csr_access_check.sv
hdl/csr_irq_ctrl.sv
hdl/csr_trap_regs.sv
hdl/csr_counters.sv
hdl/csr_file.sv
bench/csr_file_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CSR file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module csr_file_tb -f csr_file.f -o csr_sim

./obj_dir/csr_sim | tee sim.log

grep -q '^>>> PASS$' sim.log
